/* logic/dsp_cfg.svh */
`ifndef DSP_CFG_SVH
`define DSP_CFG_SVH

// Sample and channel width
`define DSP_DATA_W 16

`define DSP_N_BLOCKS 64
`define DSP_BLOCK_W 6

`define DSP_N_CHANNELS 16
`define DSP_CH_W 4

`define DSP_INSTR_W 32
`define DSP_SHIFT_W 5

// Multiply-add headroom above the full product
`define DSP_FULL_W (2 * `DSP_DATA_W + 8)

// In-flight counter, covers fetch through commit
`define DSP_FLIGHT_W 4

`endif

/* logic/dsp_pkg.sv */
`include "dsp_cfg.svh"

package dsp_pkg;

	typedef enum logic [2:0] {
		OP_NOP  = 3'd0,
		OP_MADD = 3'd1,
		OP_MUL  = 3'd2,
		OP_ADD  = 3'd3,
		OP_MOV  = 3'd4
	} opcode_e;

	// Host instruction word, exactly `DSP_INSTR_W bits
	typedef struct packed {
		opcode_e                  opcode;
		logic [`DSP_CH_W-1:0]     dest;
		logic [`DSP_CH_W-1:0]     src_a;
		logic [`DSP_CH_W-1:0]     src_b;
		logic [`DSP_CH_W-1:0]     src_c;
		logic [`DSP_SHIFT_W-1:0]  shift;
		logic                     no_sat;
		logic                     is_unsigned;
		logic [5:0]               reserved;
	} instr_t;

	typedef struct packed {
		opcode_e                  opcode;
		logic [`DSP_CH_W-1:0]     dest;
		logic [`DSP_CH_W-1:0]     src_a;
		logic [`DSP_CH_W-1:0]     src_b;
		logic [`DSP_CH_W-1:0]     src_c;
		logic [`DSP_SHIFT_W-1:0]  shift;
		logic                     no_sat;
		logic                     is_unsigned;
		logic                     writes;
		logic                     need_a;
		logic                     need_b;
		logic                     need_c;
	} decoded_t;

	typedef struct packed {
		opcode_e                        opcode;
		logic [`DSP_CH_W-1:0]           dest;
		logic [`DSP_SHIFT_W-1:0]        shift;
		logic                           no_sat;
		logic                           is_unsigned;
		logic                           writes;
		logic signed [`DSP_DATA_W-1:0]  a;
		logic signed [`DSP_DATA_W-1:0]  b;
		logic signed [`DSP_DATA_W-1:0]  c;
	} operands_t;

	typedef struct packed {
		logic                           en;
		logic [`DSP_CH_W-1:0]           addr;
		logic signed [`DSP_DATA_W-1:0]  value;
	} ch_write_t;

endpackage

/* logic/block_fetch_decode.sv */
`include "dsp_cfg.svh"

module block_fetch_decode import dsp_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     enable,
	input  logic                     tick,
	input  logic                     command_instr_write,
	input  logic [`DSP_BLOCK_W-1:0]  command_block_target,
	input  instr_t                   command_instr_write_val,
	input  logic                     retire,
	output logic                     ready,
	output logic                     dec_valid,
	input  logic                     dec_ready,
	output decoded_t                 dec
);

	instr_t instrs [`DSP_N_BLOCKS];
	logic [`DSP_BLOCK_W:0] n_running;
	logic [`DSP_BLOCK_W:0] ptr;
	logic running;
	logic running_next;
	logic rd_valid;
	instr_t rd_word;
	decoded_t rd_dec;
	logic [`DSP_FLIGHT_W-1:0] in_flight;
	logic [`DSP_FLIGHT_W-1:0] in_flight_next;
	logic tick_go;
	logic host_write;
	logic out_free;
	logic step;
	logic issue;

	assign tick_go = tick & ready;
	assign host_write = command_instr_write & ready;
	assign out_free = ~dec_valid | dec_ready;
	// Both fetch registers move together, enable holds the read stage
	assign step = enable & out_free;
	assign issue = step & running & (ptr != n_running);
	assign running_next = tick_go | (running & (ptr != n_running));

	always_comb begin
		in_flight_next = in_flight;
		if (issue && !retire) begin
			in_flight_next = in_flight + 1'b1;
		end else if (!issue && retire) begin
			in_flight_next = in_flight - 1'b1;
		end
	end

	// Instruction memory, written by the host only between runs
	always_ff @(posedge clk) begin
		if (host_write) begin
			instrs[command_block_target] <= command_instr_write_val;
		end
		if (issue) begin
			rd_word <= instrs[ptr[`DSP_BLOCK_W-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			n_running <= '0;
			ptr <= '0;
			running <= 1'b0;
			rd_valid <= 1'b0;
			dec_valid <= 1'b0;
			in_flight <= '0;
			ready <= 1'b1;
		end else begin
			if (host_write && ({1'b0, command_block_target} >= n_running)) begin
				n_running <= {1'b0, command_block_target} + 1'b1;
			end
			if (tick_go) begin
				ptr <= '0;
			end else if (issue) begin
				ptr <= ptr + 1'b1;
			end
			running <= running_next;
			if (step) begin
				rd_valid <= issue;
			end
			if (out_free) begin
				dec_valid <= rd_valid & enable;
			end
			in_flight <= in_flight_next;
			if (tick_go) begin
				ready <= 1'b0;
			end else if (!running_next && in_flight_next == '0) begin
				ready <= 1'b1;
			end
		end
	end

	always_comb begin
		rd_dec = '0;
		rd_dec.dest = rd_word.dest;
		rd_dec.src_a = rd_word.src_a;
		rd_dec.src_b = rd_word.src_b;
		rd_dec.src_c = rd_word.src_c;
		rd_dec.shift = rd_word.shift;
		rd_dec.no_sat = rd_word.no_sat;
		rd_dec.is_unsigned = rd_word.is_unsigned;
		case (rd_word.opcode)
			OP_MADD: begin
				rd_dec.opcode = OP_MADD;
				rd_dec.need_a = 1'b1;
				rd_dec.need_b = 1'b1;
				rd_dec.need_c = 1'b1;
			end
			OP_MUL: begin
				rd_dec.opcode = OP_MUL;
				rd_dec.need_a = 1'b1;
				rd_dec.need_b = 1'b1;
			end
			OP_ADD: begin
				rd_dec.opcode = OP_ADD;
				rd_dec.need_a = 1'b1;
				rd_dec.need_c = 1'b1;
			end
			OP_MOV: begin
				rd_dec.opcode = OP_MOV;
				rd_dec.need_a = 1'b1;
			end
			// Unused encodings run as NOP
			default: rd_dec.opcode = OP_NOP;
		endcase
		rd_dec.writes = (rd_dec.opcode != OP_NOP);
	end

	always_ff @(posedge clk) begin
		if (out_free && enable && rd_valid) begin
			dec <= rd_dec;
		end
	end

endmodule

/* logic/operand_fetch.sv */
`include "dsp_cfg.svh"

module operand_fetch import dsp_pkg::*; (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           dec_valid,
	output logic                           dec_ready,
	input  decoded_t                       dec,
	output logic [`DSP_CH_W-1:0]           rd_addr_a,
	output logic [`DSP_CH_W-1:0]           rd_addr_b,
	output logic [`DSP_CH_W-1:0]           rd_addr_c,
	input  logic signed [`DSP_DATA_W-1:0]  rd_data_a,
	input  logic signed [`DSP_DATA_W-1:0]  rd_data_b,
	input  logic signed [`DSP_DATA_W-1:0]  rd_data_c,
	input  ch_write_t                      commit,
	output logic                           op_valid,
	output operands_t                      ops
);

	logic [`DSP_N_CHANNELS-1:0] pending;
	logic [`DSP_N_CHANNELS-1:0] pending_clr;
	logic [`DSP_N_CHANNELS-1:0] pending_set;
	logic [`DSP_N_CHANNELS-1:0] pending_live;
	logic hazard;
	logic accept;

	assign rd_addr_a = dec.src_a;
	assign rd_addr_b = dec.src_b;
	assign rd_addr_c = dec.src_c;

	// A commit this cycle already reaches the read ports, so its bit no longer blocks
	always_comb begin
		pending_clr = '0;
		if (commit.en) begin
			pending_clr[commit.addr] = 1'b1;
		end
		pending_live = pending & ~pending_clr;
	end

	// RAW on each needed source, WAW on the destination
	assign hazard = (dec.need_a & pending_live[dec.src_a])
		| (dec.need_b & pending_live[dec.src_b])
		| (dec.need_c & pending_live[dec.src_c])
		| (dec.writes & pending_live[dec.dest]);

	assign dec_ready = ~hazard;
	assign accept = dec_valid & dec_ready;

	always_comb begin
		pending_set = '0;
		if (accept && dec.writes) begin
			pending_set[dec.dest] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			op_valid <= 1'b0;
		end else begin
			pending <= pending_live | pending_set;
			op_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ops.opcode <= dec.opcode;
			ops.dest <= dec.dest;
			ops.shift <= dec.shift;
			ops.no_sat <= dec.no_sat;
			ops.is_unsigned <= dec.is_unsigned;
			ops.writes <= dec.writes;
			ops.a <= rd_data_a;
			ops.b <= rd_data_b;
			ops.c <= rd_data_c;
		end
	end

endmodule

/* logic/channel_file.sv */
`include "dsp_cfg.svh"

module channel_file import dsp_pkg::*; (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           tick,
	input  logic signed [`DSP_DATA_W-1:0]  sample_in,
	output logic signed [`DSP_DATA_W-1:0]  sample_out,
	input  logic [`DSP_CH_W-1:0]           rd_addr_a,
	input  logic [`DSP_CH_W-1:0]           rd_addr_b,
	input  logic [`DSP_CH_W-1:0]           rd_addr_c,
	output logic signed [`DSP_DATA_W-1:0]  rd_data_a,
	output logic signed [`DSP_DATA_W-1:0]  rd_data_b,
	output logic signed [`DSP_DATA_W-1:0]  rd_data_c,
	input  ch_write_t                      commit
);

	logic signed [`DSP_DATA_W-1:0] ch [`DSP_N_CHANNELS];

	// Write-through read, the committing value wins over the stored one
	function automatic logic signed [`DSP_DATA_W-1:0] read_port(
		input logic [`DSP_CH_W-1:0] addr
	);
		if (commit.en && commit.addr == addr) begin
			return commit.value;
		end
		return ch[addr];
	endfunction

	always_comb begin
		rd_data_a = read_port(rd_addr_a);
		rd_data_b = read_port(rd_addr_b);
		rd_data_c = read_port(rd_addr_c);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DSP_N_CHANNELS; i++) begin
				ch[i] <= '0;
			end
			sample_out <= '0;
		end else begin
			if (commit.en) begin
				ch[commit.addr] <= commit.value;
			end
			// Channel 1 takes the new sample, channel 0 holds last run's output
			if (tick) begin
				ch[1] <= sample_in;
				sample_out <= ch[0];
			end
		end
	end

endmodule

/* logic/madd_pipeline.sv */
`include "dsp_cfg.svh"

module madd_pipeline import dsp_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       op_valid,
	input  operands_t  ops,
	output ch_write_t  commit,
	output logic       retire
);

	logic [2*`DSP_DATA_W-1:0] prod_u;
	logic signed [2*`DSP_DATA_W-1:0] prod_s;
	logic signed [`DSP_FULL_W-1:0] prod;
	logic signed [`DSP_FULL_W-1:0] sum;
	logic signed [`DSP_FULL_W-1:0] shifted;
	logic signed [`DSP_DATA_W-1:0] low;
	logic signed [`DSP_DATA_W-1:0] sat_val;

	logic s1_valid;
	logic s2_valid;
	opcode_e s1_opcode;
	logic [`DSP_CH_W-1:0] s1_dest;
	logic [`DSP_CH_W-1:0] s2_dest;
	logic [`DSP_SHIFT_W-1:0] s1_shift;
	logic s1_no_sat;
	logic s2_no_sat;
	logic s1_writes;
	logic s2_writes;
	logic signed [`DSP_FULL_W-1:0] s1_prod;
	logic signed [`DSP_DATA_W-1:0] s1_c;
	logic signed [`DSP_FULL_W-1:0] s2_val;

	// Stage 1 multiply
	always_comb begin
		prod_u = $unsigned(ops.a) * $unsigned(ops.b);
		prod_s = ops.a * ops.b;
		if (ops.opcode == OP_ADD || ops.opcode == OP_MOV) begin
			prod = ops.a;
		end else if (ops.is_unsigned) begin
			prod = $signed({{(`DSP_FULL_W - 2*`DSP_DATA_W){1'b0}}, prod_u});
		end else begin
			prod = prod_s;
		end
	end

	// Stage 2 accumulate and shift
	always_comb begin
		sum = s1_prod;
		if (s1_opcode == OP_MADD || s1_opcode == OP_ADD) begin
			sum = s1_prod + s1_c;
		end
		shifted = sum >>> s1_shift;
	end

	// Stage 3 saturate unless the value fits in a channel
	always_comb begin
		low = s2_val[`DSP_DATA_W-1:0];
		if (s2_no_sat || s2_val == low) begin
			sat_val = low;
		end else if (s2_val[`DSP_FULL_W-1]) begin
			sat_val = {1'b1, {(`DSP_DATA_W-1){1'b0}}};
		end else begin
			sat_val = {1'b0, {(`DSP_DATA_W-1){1'b1}}};
		end
	end

	always_ff @(posedge clk) begin
		s1_opcode <= ops.opcode;
		s1_dest <= ops.dest;
		s1_shift <= ops.shift;
		s1_no_sat <= ops.no_sat;
		s1_writes <= ops.writes;
		s1_prod <= prod;
		s1_c <= ops.c;
		s2_dest <= s1_dest;
		s2_no_sat <= s1_no_sat;
		s2_writes <= s1_writes;
		s2_val <= shifted;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			commit.en <= 1'b0;
			retire <= 1'b0;
		end else begin
			s1_valid <= op_valid;
			s2_valid <= s1_valid;
			commit.en <= s2_valid & s2_writes;
			// NOPs retire too so the in-flight count drains
			retire <= s2_valid;
		end
		commit.addr <= s2_dest;
		commit.value <= sat_val;
	end

endmodule

/* logic/dsp_core.sv */
`include "dsp_cfg.svh"

module dsp_core import dsp_pkg::*; (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           enable,
	input  logic                           tick,
	input  logic signed [`DSP_DATA_W-1:0]  sample_in,
	output logic signed [`DSP_DATA_W-1:0]  sample_out,
	output logic                           ready,
	input  logic                           command_instr_write,
	input  logic [`DSP_BLOCK_W-1:0]        command_block_target,
	input  instr_t                         command_instr_write_val
);

	logic dec_valid;
	logic dec_ready;
	decoded_t dec;
	logic op_valid;
	operands_t ops;
	ch_write_t commit;
	logic retire;
	logic [`DSP_CH_W-1:0] rd_addr_a;
	logic [`DSP_CH_W-1:0] rd_addr_b;
	logic [`DSP_CH_W-1:0] rd_addr_c;
	logic signed [`DSP_DATA_W-1:0] rd_data_a;
	logic signed [`DSP_DATA_W-1:0] rd_data_b;
	logic signed [`DSP_DATA_W-1:0] rd_data_c;

	// Ticks arriving mid-run are dropped, so the channels only see accepted ones
	wire tick_go = tick & ready;

	block_fetch_decode fetch_decode (
		.clk                     (clk),
		.reset                   (reset),
		.enable                  (enable),
		.tick                    (tick),
		.command_instr_write     (command_instr_write),
		.command_block_target    (command_block_target),
		.command_instr_write_val (command_instr_write_val),
		.retire                  (retire),
		.ready                   (ready),
		.dec_valid               (dec_valid),
		.dec_ready               (dec_ready),
		.dec                     (dec)
	);

	operand_fetch op_fetch (
		.clk       (clk),
		.reset     (reset),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec       (dec),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_addr_c (rd_addr_c),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.rd_data_c (rd_data_c),
		.commit    (commit),
		.op_valid  (op_valid),
		.ops       (ops)
	);

	channel_file channels (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick_go),
		.sample_in  (sample_in),
		.sample_out (sample_out),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_addr_c  (rd_addr_c),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.rd_data_c  (rd_data_c),
		.commit     (commit)
	);

	madd_pipeline madd (
		.clk      (clk),
		.reset    (reset),
		.op_valid (op_valid),
		.ops      (ops),
		.commit   (commit),
		.retire   (retire)
	);

endmodule

/* verif/dsp_core_checker.sv */
`include "dsp_cfg.svh"

module dsp_core_checker (
	input logic                           clk,
	input logic                           reset,
	input logic                           tick,
	input logic                           ready,
	input logic signed [`DSP_DATA_W-1:0]  sample_out
);
	timeunit 1ns;
	timeprecision 100ps;

	// Cycles spent with ready low since the last time it was high
	logic [15:0] low_cycles;

	// Number of assertion failures seen so far
	int assert_failures = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			low_cycles <= '0;
		end else if (ready) begin
			low_cycles <= '0;
		end else begin
			low_cycles <= low_cycles + 1'b1;
		end
	end

	ready_after_reset: assert property (@(posedge clk) reset |=> ready)
		else begin
			assert_failures++;
			$error("ready is low in the cycle after reset");
		end

	// sample_out only moves on an accepted tick
	sample_out_on_tick: assert property (@(posedge clk) disable iff (reset)
		!$stable(sample_out) |-> $past(tick && ready))
		else begin
			assert_failures++;
			$error("sample_out changed without an accepted tick");
		end

	ready_low_bounded: assert property (@(posedge clk) disable iff (reset)
		low_cycles <= 16'd300)
		else begin
			assert_failures++;
			$error("ready stayed low for more than 300 cycles");
		end

endmodule

bind dsp_core dsp_core_checker checks (.*);

/* verif/dsp_core_tb.sv */
`include "dsp_cfg.svh"

module dsp_core_tb import dsp_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 6;
	localparam int READY_LIMIT = 300;

	logic clk;
	logic reset;
	logic enable;
	logic tick;
	logic signed [`DSP_DATA_W-1:0] sample_in;
	logic signed [`DSP_DATA_W-1:0] sample_out;
	logic ready;
	logic command_instr_write;
	logic [`DSP_BLOCK_W-1:0] command_block_target;
	instr_t command_instr_write_val;

	// Reference model of the channels and the loaded program
	logic signed [`DSP_DATA_W-1:0] model_ch [`DSP_N_CHANNELS];
	instr_t model_prog [`DSP_N_BLOCKS];
	int model_len;
	logic signed [`DSP_DATA_W-1:0] expected_out;

	logic [15:0] lfsr_state;
	int errors;
	int checks;

	dsp_core uut (
		.clk                     (clk),
		.reset                   (reset),
		.enable                  (enable),
		.tick                    (tick),
		.sample_in               (sample_in),
		.sample_out              (sample_out),
		.ready                   (ready),
		.command_instr_write     (command_instr_write),
		.command_block_target    (command_block_target),
		.command_instr_write_val (command_instr_write_val)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic instr_t make_instr(
		input opcode_e op,
		input int dest,
		input int src_a,
		input int src_b,
		input int src_c,
		input int shift,
		input bit no_sat,
		input bit is_unsigned
	);
		instr_t w;
		w = '0;
		w.opcode = op;
		w.dest = dest[`DSP_CH_W-1:0];
		w.src_a = src_a[`DSP_CH_W-1:0];
		w.src_b = src_b[`DSP_CH_W-1:0];
		w.src_c = src_c[`DSP_CH_W-1:0];
		w.shift = shift[`DSP_SHIFT_W-1:0];
		w.no_sat = no_sat;
		w.is_unsigned = is_unsigned;
		return w;
	endfunction

	// Product (or a), plus c, arithmetic shift, then saturate or wrap
	function automatic logic signed [15:0] model_result(
		input instr_t w,
		input logic signed [15:0] a,
		input logic signed [15:0] b,
		input logic signed [15:0] c
	);
		longint v;
		longint ua;
		longint ub;
		ua = {48'h0, a};
		ub = {48'h0, b};
		if (w.opcode == OP_ADD || w.opcode == OP_MOV) begin
			v = a;
		end else if (w.is_unsigned) begin
			v = ua * ub;
		end else begin
			v = longint'(a) * longint'(b);
		end
		if (w.opcode == OP_MADD || w.opcode == OP_ADD) begin
			v = v + c;
		end
		v = v >>> w.shift;
		if (w.no_sat) begin
			return v[15:0];
		end
		if (v > 32767) begin
			return 16'h7fff;
		end
		if (v < -32768) begin
			return 16'h8000;
		end
		return v[15:0];
	endfunction

	task automatic model_run();
		instr_t w;
		for (int i = 0; i < model_len; i++) begin
			w = model_prog[i];
			if (w.opcode != OP_NOP) begin
				model_ch[w.dest] = model_result(w, model_ch[w.src_a], model_ch[w.src_b],
					model_ch[w.src_c]);
			end
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error %s: got 0x%04h, expected 0x%04h", name, got, expected);
		end
	endtask

	task automatic reset_dut();
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < `DSP_N_CHANNELS; i++) begin
			model_ch[i] = '0;
		end
		model_len = 0;
	endtask

	task automatic write_block(input int blk, input instr_t w, input bit honored);
		command_instr_write = 1'b1;
		command_block_target = blk[`DSP_BLOCK_W-1:0];
		command_instr_write_val = w;
		@(posedge clk);
		#1;
		command_instr_write = 1'b0;
		if (honored) begin
			model_prog[blk] = w;
			if (blk >= model_len) begin
				model_len = blk + 1;
			end
		end
	endtask

	// New sample lands in channel 1 as channel 0 is captured
	task automatic start_tick(input logic signed [15:0] s);
		check_value("ready", ready, 16'h1);
		expected_out = model_ch[0];
		model_ch[1] = s;
		model_run();
		sample_in = s;
		tick = 1'b1;
		@(posedge clk);
		#1;
		tick = 1'b0;
	endtask

	task automatic finish_tick();
		int n;
		n = 0;
		while (ready !== 1'b1 && n < READY_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ready !== 1'b1) begin
			errors++;
			$display("ready did not return within %0d cycles after a tick", READY_LIMIT);
		end
		check_value("sample_out", sample_out, expected_out);
	endtask

	task automatic run_tick(input logic signed [15:0] s);
		start_tick(s);
		finish_tick();
	endtask

	task automatic test_reset_state();
		reset_dut();
		check_value("ready", ready, 16'h1);
		check_value("sample_out", sample_out, 16'h0);
		run_tick(random_bits(16));
		run_tick(random_bits(16));
		check_value("sample_out", sample_out, 16'h0);
	endtask

	task automatic test_mov_passthrough();
		logic signed [15:0] prev;
		logic signed [15:0] s;
		reset_dut();
		write_block(0, make_instr(OP_MOV, 0, 1, 0, 0, 0, 0, 0), 1'b1);
		prev = '0;
		repeat (6) begin
			s = random_bits(16);
			run_tick(s);
			check_value("sample_out", sample_out, prev);
			prev = s;
		end
	endtask

	task automatic test_arith_ops();
		opcode_e op_list [3];
		int shift_list [3];
		op_list[0] = OP_MADD;
		op_list[1] = OP_MUL;
		op_list[2] = OP_ADD;
		shift_list[0] = 0;
		shift_list[1] = 4;
		shift_list[2] = 15;
		reset_dut();
		// Delay line so a, b and c hold three different samples
		write_block(1, make_instr(OP_MOV, 0, 4, 0, 0, 0, 0, 0), 1'b1);
		write_block(2, make_instr(OP_MOV, 3, 2, 0, 0, 0, 0, 0), 1'b1);
		write_block(3, make_instr(OP_MOV, 2, 1, 0, 0, 0, 0, 0), 1'b1);
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				write_block(0, make_instr(op_list[i], 4, 2, 3, 1, shift_list[j], 0, 0), 1'b1);
				repeat (4) run_tick(random_bits(16));
			end
		end
	endtask

	task automatic sat_case(input bit no_sat, input bit is_unsigned, input logic [15:0] x,
		input logic [15:0] y, input logic [15:0] expected);
		write_block(0, make_instr(OP_MUL, 0, 2, 1, 0, 0, no_sat, is_unsigned), 1'b1);
		write_block(1, make_instr(OP_MOV, 2, 1, 0, 0, 0, 0, 0), 1'b1);
		run_tick(x);
		run_tick(y);
		run_tick(16'h0);
		check_value("sample_out", sample_out, expected);
	endtask

	task automatic test_saturation();
		reset_dut();
		sat_case(1'b0, 1'b0, 16'h7fff, 16'h7fff, 16'h7fff);
		sat_case(1'b0, 1'b0, 16'h8000, 16'h7fff, 16'h8000);
		sat_case(1'b1, 1'b0, 16'h7fff, 16'h7fff, 16'h0001);
		sat_case(1'b1, 1'b0, 16'h8000, 16'h7fff, 16'h8000);
		// Unsigned 0x8000 x 2 overflows upward, 0xffff x 1 stays positive
		sat_case(1'b0, 1'b1, 16'h8000, 16'h0002, 16'h7fff);
		sat_case(1'b0, 1'b1, 16'hffff, 16'h0001, 16'h7fff);
	endtask

	task automatic test_dependent_chain();
		reset_dut();
		write_block(0, make_instr(OP_MUL, 2, 1, 1, 0, 15, 0, 0), 1'b1);
		write_block(1, make_instr(OP_ADD, 3, 2, 0, 1, 0, 0, 0), 1'b1);
		write_block(2, make_instr(OP_MOV, 0, 3, 0, 0, 0, 0, 0), 1'b1);
		repeat (5) run_tick(random_bits(16));
	endtask

	task automatic test_write_while_busy();
		reset_dut();
		write_block(0, make_instr(OP_MOV, 0, 1, 0, 0, 0, 0, 0), 1'b1);
		start_tick(random_bits(16));
		check_value("ready", ready, 16'h0);
		// Would zero channel 0 from the idle channel 6 if taken
		write_block(1, make_instr(OP_MOV, 0, 6, 0, 0, 0, 0, 0), 1'b0);
		finish_tick();
		run_tick(random_bits(16));
		run_tick(random_bits(16));
		write_block(1, make_instr(OP_ADD, 0, 0, 0, 1, 0, 0, 0), 1'b1);
		repeat (3) run_tick(random_bits(16));
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_instr_write = 1'b0;
		command_block_target = '0;
		command_instr_write_val = '0;
		errors = 0;
		checks = 0;
		model_len = 0;
		lfsr_state = 16'd85;
		test_reset_state();
		test_mov_passthrough();
		test_arith_ops();
		test_saturation();
		test_dependent_chain();
		test_write_while_busy();
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			uut.checks.assert_failures);
		if (errors == 0 && uut.checks.assert_failures == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(400 * NUM_TESTS * CLK_PERIOD);
		$display("Watchdog expired before the tests finished, %0d errors so far", errors);
		$display("Test failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+logic
logic/dsp_pkg.sv
logic/block_fetch_decode.sv
logic/operand_fetch.sv
logic/channel_file.sv
logic/madd_pipeline.sv
logic/dsp_core.sv
verif/dsp_core_checker.sv
verif/dsp_core_tb.sv
